// ==== hw/arb_pkg.sv ====
package arb_pkg;

  // number of merged byte streams
  localparam int NUM_INPUTS = 4;

  // payload width, one byte per beat
  localparam int DATA_W = 8;

  // width of the source index
  localparam int SRC_W = $clog2(NUM_INPUTS);

  // one payload byte
  typedef logic [DATA_W-1:0] data_t;

  // index of the input a beat came from
  typedef logic [SRC_W-1:0] src_t;

  // one bit per input
  // push, full, head valid, grant and pop all use this
  typedef logic [NUM_INPUTS-1:0] req_mask_t;

  // output item, source tag on top of the payload
  // ten bits in total
  typedef struct packed {
    src_t  src;
    data_t data;
  } beat_t;

endpackage

// ==== hw/ingress_fifo.sv ====
`timescale 1ns/1ps

module ingress_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           push,
  input  arb_pkg::data_t din,
  output logic           full,
  input  logic           pop,
  output logic           head_valid,
  output arb_pkg::data_t head_data
);

  import arb_pkg::*;

  // depth is a power of two, pointers wrap on their own
  localparam int PTR_W = $clog2(FIFO_DEPTH);

  typedef logic [PTR_W-1:0] ptr_t;
  // one extra bit so a full queue is told apart from an empty one
  typedef logic [PTR_W:0]   cnt_t;

  data_t mem [FIFO_DEPTH];
  ptr_t  wr_ptr;
  ptr_t  rd_ptr;
  cnt_t  count;
  logic  do_push;
  logic  do_pop;

  // pushes into a full queue are lost
  assign do_push = push && !full;
  // pop only ever acts on a real head
  assign do_pop = pop && head_valid;

  // storage array
  always_ff @(posedge clk)
  begin
    if (do_push)
    begin
      mem[wr_ptr] <= din;
    end
  end

  // pointers and fill level
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
      begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop)
      begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      // simultaneous push and pop leaves the count alone
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // status levels straight from the registered count
  assign full       = (count == cnt_t'(FIFO_DEPTH));
  assign head_valid = (count != '0);

  // first word falls through, head is the oldest entry
  assign head_data = mem[rd_ptr];

  // sender has to respect in_ready
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(push && full)
  ) else $error("ingress_fifo: push while full");

  // grant stage only pops a queue that shows a head
  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(pop && !head_valid)
  ) else $error("ingress_fifo: pop while empty");

endmodule

// ==== hw/rr_grant.sv ====
`timescale 1ns/1ps

module rr_grant (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  arb_pkg::req_mask_t                      head_valid,
  input  arb_pkg::data_t [arb_pkg::NUM_INPUTS-1:0] head_data,
  output arb_pkg::req_mask_t                      pop,
  output logic                                    cand_valid,
  output arb_pkg::beat_t                          cand_beat,
  input  logic                                    cand_ready
);

  import arb_pkg::*;

  // input that gets first look next time
  src_t ptr;
  // chosen input for this cycle
  src_t win;
  logic xfer;

  // anything waiting at all
  assign cand_valid = |head_valid;

  // beat moves into the egress stage
  assign xfer = cand_valid && cand_ready;

  // scan from the pointer upward, wrapping past the last input
  always_comb
  begin : pick_blk
    src_t idx;
    logic found;
    idx   = ptr;
    found = 1'b0;
    win   = ptr;
    for (int i = 0; i < NUM_INPUTS; i++)
    begin
      idx = src_t'(ptr + i);
      if (!found && head_valid[idx])
      begin
        win   = idx;
        found = 1'b1;
      end
    end
  end

  // tag the chosen head with its index
  always_comb
  begin
    cand_beat.src  = win;
    cand_beat.data = head_data[win];
  end

  // one pop per transfer, on the winner only
  always_comb
  begin
    pop = '0;
    if (xfer)
    begin
      pop[win] = 1'b1;
    end
  end

  // pointer jumps to just past the winner
  // so the winner goes to the back of the line
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      ptr <= '0;
    end
    else if (xfer)
    begin
      ptr <= win + 1'b1;
    end
  end

  // at most one queue popped, and only a queue with a head
  a_pop_legal: assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(pop) && ((pop & ~head_valid) == '0)
  ) else $error("rr_grant: illegal pop vector %b, heads %b", pop, head_valid);

endmodule

// ==== hw/egress_skid.sv ====
`timescale 1ns/1ps

module egress_skid (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           cand_valid,
  input  arb_pkg::beat_t cand_beat,
  output logic           cand_ready,
  output logic           out_valid,
  output arb_pkg::beat_t out_beat,
  input  logic           out_ready
);

  import arb_pkg::*;

  // spare slot, only used while the output slot is stalled
  beat_t spare_beat;
  logic  spare_valid;
  logic  take;
  logic  give;

  // room for another beat as long as the spare is free
  // comes from a flop, never from out_ready
  assign cand_ready = !spare_valid;

  assign take = cand_valid && cand_ready;
  assign give = out_valid && out_ready;

  // control flags
  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      out_valid   <= 1'b0;
      spare_valid <= 1'b0;
    end
    else if (!out_valid || give)
    begin
      // output slot frees up, refill from spare first
      if (spare_valid)
      begin
        out_valid   <= 1'b1;
        spare_valid <= 1'b0;
      end
      else
      begin
        out_valid <= take;
      end
    end
    else if (take)
    begin
      // output stalled, park the new beat
      spare_valid <= 1'b1;
    end
  end

  // payload registers
  always_ff @(posedge clk)
  begin
    if (!out_valid || give)
    begin
      if (spare_valid)
      begin
        out_beat <= spare_beat;
      end
      else if (take)
      begin
        out_beat <= cand_beat;
      end
    end
    else if (take)
    begin
      spare_beat <= cand_beat;
    end
  end

  // stalled beat must not move or vanish
  a_hold_stall: assert property (
    @(posedge clk) disable iff (!rst_n)
    (out_valid && !out_ready) |=> (out_valid && $stable(out_beat))
  ) else $error("egress_skid: output changed under back-pressure");

endmodule

// ==== hw/rr_merge_top.sv ====
`timescale 1ns/1ps

module rr_merge_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic                                     clk,
  input  logic                                     rst_n,
  input  arb_pkg::req_mask_t                       push,
  input  arb_pkg::data_t [arb_pkg::NUM_INPUTS-1:0] din,
  output arb_pkg::req_mask_t                       in_ready,
  output logic                                     out_valid,
  output arb_pkg::beat_t                           out_beat,
  input  logic                                     out_ready
);

  import arb_pkg::*;

  // queue status and heads
  req_mask_t                 fifo_full;
  req_mask_t                 head_valid;
  data_t [NUM_INPUTS-1:0]    head_data;
  // pop strobes back from the grant stage
  req_mask_t                 pop;

  // grant to egress handshake
  logic  cand_valid;
  logic  cand_ready;
  beat_t cand_beat;

  // senders see the inverse of each full level
  assign in_ready = ~fifo_full;

  // one queue per input
  for (genvar g = 0; g < NUM_INPUTS; g++)
  begin : g_ingress
    ingress_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
      .clk        (clk),
      .rst_n      (rst_n),
      .push       (push[g]),
      .din        (din[g]),
      .full       (fifo_full[g]),
      .pop        (pop[g]),
      .head_valid (head_valid[g]),
      .head_data  (head_data[g])
    );
  end

  // fair pick among the queue heads
  rr_grant u_grant (
    .clk        (clk),
    .rst_n      (rst_n),
    .head_valid (head_valid),
    .head_data  (head_data),
    .pop        (pop),
    .cand_valid (cand_valid),
    .cand_beat  (cand_beat),
    .cand_ready (cand_ready)
  );

  // output register with back-pressure slack
  egress_skid u_egress (
    .clk        (clk),
    .rst_n      (rst_n),
    .cand_valid (cand_valid),
    .cand_beat  (cand_beat),
    .cand_ready (cand_ready),
    .out_valid  (out_valid),
    .out_beat   (out_beat),
    .out_ready  (out_ready)
  );

endmodule

// ==== tests/rr_merge_tb.sv ====
`timescale 1ns/1ps

module rr_merge_tb;

  import arb_pkg::*;

  localparam int    CLK_PERIOD   = 20;
  localparam int    RST_CYCLES   = 16;
  localparam int    FIFO_DEPTH   = 4;
  localparam int    MAX_STEPS    = 32;
  localparam int    DRAIN_MARGIN = 100;
  localparam logic [31:0] LFSR_SEED = 32'h1888;
  localparam string VEC_FILE     = "tests/rr_merge_vectors.txt";

  logic                   clk;
  logic                   rst_n;
  req_mask_t              push;
  data_t [NUM_INPUTS-1:0] din;
  req_mask_t              in_ready;
  logic                   out_valid;
  beat_t                  out_beat;
  logic                   out_ready;

  // four words per step
  // push mask, out_ready mode, repeat count and expected in_ready
  logic [15:0] vec_mem [0:4*MAX_STEPS-1];
  int          num_steps;
  int          total_cycles = 0;
  int          check_count  = 0;
  int          err_count    = 0;
  int          beats_out    = 0;

  // reference model of the ingress queues, egress contents and pointer
  data_t       mq [NUM_INPUTS][$];
  beat_t       eq [$];
  src_t        mptr;
  data_t       seq_cnt [NUM_INPUTS];
  logic [31:0] lfsr;
  // back-pressure hold, latency probe and round-robin tracking
  logic        hold_valid;
  beat_t       hold_beat;
  int          lat_wait;
  src_t        lat_src;
  int          rr_run;
  src_t        last_src;

  rr_merge_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_dut (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (push),
    .din       (din),
    .in_ready  (in_ready),
    .out_valid (out_valid),
    .out_beat  (out_beat),
    .out_ready (out_ready)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // bytes held anywhere in the model
  function automatic int model_held();
    int n;
    n = eq.size();
    for (int i = 0; i < NUM_INPUTS; i++)
      n += mq[i].size();
    return n;
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (expected !== actual)
    begin
      err_count++;
      $display("[ERROR] %0t %s expected %0h actual %0h", $time, name, expected, actual);
    end
  endtask

  // one clock per call
  // check at the falling edge, then drive and advance the model to the next rise
  task automatic step_cycle(input req_mask_t mask, input logic [1:0] mode);
    req_mask_t exp_ready;
    req_mask_t pmask;
    logic      rdy;
    logic      found;
    logic      take;
    logic      rr_mode;
    src_t      win;
    src_t      idx;
    beat_t     nb;
    for (int i = 0; i < NUM_INPUTS; i++)
      exp_ready[i] = (mq[i].size() < FIFO_DEPTH);
    check_value("in_ready", exp_ready, in_ready);
    check_value("out_valid", eq.size() > 0, out_valid);
    if (eq.size() > 0)
      check_value("out_beat", eq[0], out_beat);
    // stalled beat stays put
    if (hold_valid)
      check_value("out_beat held", hold_beat, out_beat);
    // single byte into an idle system shows up two edges later
    if (lat_wait > 0)
    begin
      lat_wait--;
      if (lat_wait == 0)
      begin
        check_value("out_valid latency", 1, out_valid);
        check_value("out_beat.src latency", lat_src, out_beat.src);
      end
    end
    // sender only pushes where ready
    pmask = mask & in_ready;
    case (mode)
      2'd0: rdy = 1'b0;
      2'd1: rdy = 1'b1;
      default:
      begin
        lfsr = lfsr_step(lfsr);
        rdy  = lfsr[0];
      end
    endcase
    push      = pmask;
    out_ready = rdy;
    for (int i = 0; i < NUM_INPUTS; i++)
      din[i] = seq_cnt[i];
    if (model_held() == 0 && $onehot(pmask))
    begin
      lat_wait = 2;
      for (int i = 0; i < NUM_INPUTS; i++)
        if (pmask[i])
          lat_src = src_t'(i);
    end
    hold_valid = out_valid && !rdy;
    hold_beat  = out_beat;
    // first non-empty queue at or after the pointer
    found = 1'b0;
    win   = mptr;
    for (int i = 0; i < NUM_INPUTS; i++)
    begin
      idx = src_t'(mptr + i);
      if (!found && mq[idx].size() > 0)
      begin
        found = 1'b1;
        win   = idx;
      end
    end
    // egress takes while fewer than two beats are held
    take    = found && (eq.size() < 2);
    rr_mode = (mask == {NUM_INPUTS{1'b1}}) && (mode == 2'd1);
    if (!rr_mode)
      rr_run = 0;
    if (eq.size() > 0 && rdy)
    begin
      // with all four busy the sources rotate 0 1 2 3
      if (rr_mode)
      begin
        if (rr_run >= 3)
          check_value("out_beat.src order", src_t'(last_src + 1'b1), out_beat.src);
        rr_run++;
      end
      last_src = eq[0].src;
      nb       = eq.pop_front();
      beats_out++;
    end
    if (take)
    begin
      nb.src  = win;
      nb.data = mq[win].pop_front();
      eq.push_back(nb);
      mptr = src_t'(win + 1'b1);
    end
    for (int i = 0; i < NUM_INPUTS; i++)
      if (pmask[i])
      begin
        mq[i].push_back(seq_cnt[i]);
        seq_cnt[i]++;
      end
    @(negedge clk);
  endtask

  initial
  begin : main
    logic [15:0] exp_word;
    rst_n      = 1'b0;
    push       = '0;
    din        = '0;
    out_ready  = 1'b0;
    lfsr       = LFSR_SEED;
    mptr       = '0;
    hold_valid = 1'b0;
    lat_wait   = 0;
    rr_run     = 0;
    last_src   = '0;
    for (int i = 0; i < NUM_INPUTS; i++)
      seq_cnt[i] = '0;
    $readmemh(VEC_FILE, vec_mem);
    // zero repeat count closes the list
    num_steps = 0;
    while (num_steps < MAX_STEPS && vec_mem[4*num_steps+2] != 0)
    begin
      total_cycles += vec_mem[4*num_steps+2];
      num_steps++;
    end
    if (num_steps == 0)
    begin
      $display("no stimulus steps were read from %s", VEC_FILE);
      err_count++;
    end
    repeat (RST_CYCLES)
    begin
      @(negedge clk);
      check_value("out_valid in reset", 0, out_valid);
      check_value("in_ready in reset", {NUM_INPUTS{1'b1}}, in_ready);
    end
    rst_n = 1'b1;
    for (int s = 0; s < num_steps; s++)
    begin
      repeat (vec_mem[4*s+2])
        step_cycle(vec_mem[4*s][NUM_INPUTS-1:0], vec_mem[4*s+1][1:0]);
      // full levels at the end of the step
      // values above f are not checked
      exp_word = vec_mem[4*s+3];
      if (exp_word <= 16'hf)
        check_value("in_ready after step", exp_word, in_ready);
    end
    if (model_held() != 0)
    begin
      $display("model still holds %0d bytes after the final drain", model_held());
      err_count++;
    end
    check_value("out_valid after drain", 0, out_valid);
    $display("checks %0d beats %0d errors %0d", check_count, beats_out, err_count);
    if (err_count == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // limit from the summed step lengths
  initial
  begin : watchdog
    wait (total_cycles > 0);
    #((RST_CYCLES + total_cycles + DRAIN_MARGIN) * CLK_PERIOD);
    $display("watchdog expired, run did not finish within %0d cycles",
             RST_CYCLES + total_cycles + DRAIN_MARGIN);
    $display("sim failed");
    $finish;
  end

endmodule

// ==== tests/rr_merge_vectors.txt ====
// push mask, out_ready mode (0 low, 1 high, 2 random), repeat count, expected in_ready
// all hex, an expected value above f is not checked, a zero count ends the list
0 1 2 f
// single bytes into an idle system
1 1 1 f
0 1 4 f
4 1 1 f
0 1 4 f
// all four pushing, output always ready
f 1 14 2
0 1 14 f
// input 1 alone against a stalled output
2 0 8 d
0 0 3 d
0 1 a f
// random back-pressure
f 2 28 10
5 2 1e 10
// final drain
0 1 28 f
0 0 0 0

// ==== src.f ====
hw/arb_pkg.sv
hw/ingress_fifo.sv
hw/rr_grant.sv
hw/egress_skid.sv
hw/rr_merge_top.sv
tests/rr_merge_tb.sv

// ==== Bender.yml ====
package:
  name: rr_merge

sources:
  - hw/arb_pkg.sv
  - hw/ingress_fifo.sv
  - hw/rr_grant.sv
  - hw/egress_skid.sv
  - hw/rr_merge_top.sv
  - target: test
    files:
      - tests/rr_merge_tb.sv
